// ==== src/zports_pkg.sv ====
//////////////////////////////
// shared port addresses, extension register indices,
// widths and reset values for the z80 port block
//////////////////////////////

package zports_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int BYTE_W   = 8; // z80 data byte
	localparam int KEYS_W   = 5; // keyboard columns on #FE
	localparam int KJOY_W   = 5; // kempston joystick bits
	localparam int FMADDR_W = 5; // font map address

	// screen page after reset, normal screen at page 5
	localparam logic [BYTE_W-1:0] VPAGE_RESET = 8'h05;

	//////////////////////////////
	// decoded low address bytes
	//////////////////////////////

	typedef enum logic [7:0]
	{
		PORT_FE = 8'hFE, // keyboard, tape, border
		PORT_F6 = 8'hF6, // keyboard alias
		PORT_FD = 8'hFD, // 7ffd paging
		PORT_F7 = 8'hF7, // eff7 paging
		PORT_XT = 8'hAF, // extension registers, index on a[15:8]
		KJOY    = 8'h1F, // kempston joystick
		KMOUSE  = 8'hDF, // kempston mouse
		IDE_10  = 8'h10, // data, low byte
		IDE_11  = 8'h11, // data, high byte (not on the device)
		IDE_30  = 8'h30,
		IDE_50  = 8'h50,
		IDE_70  = 8'h70,
		IDE_90  = 8'h90,
		IDE_B0  = 8'hB0,
		IDE_D0  = 8'hD0,
		IDE_F0  = 8'hF0,
		IDE_C8  = 8'hC8  // control block, goes out on cs1
	} port_addr_e;

	//////////////////////////////
	// #nnAF register indices
	//////////////////////////////

	typedef enum logic [7:0]
	{
		XT_VCONFIG = 8'd0,
		XT_VPAGE   = 8'd1,
		XT_XOFFSL  = 8'd2,
		XT_XOFFSH  = 8'd3,
		XT_YOFFSL  = 8'd4,
		XT_YOFFSH  = 8'd5,
		XT_FMADDR  = 8'd21
	} xt_reg_e;

endpackage

// ==== src/zbus_decoder.sv ====
//////////////////////////////
// z80 i/o bus front end: one-cycle port strobes on zclk
// and the address decode flags shared by the register blocks
//////////////////////////////

module zbus_decoder
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,

	output logic        port_wr,     // one zclk after io write starts
	output logic        port_rd,     // one zclk after io read starts
	output logic        iord,        // raw io read level
	output logic        is_fe,
	output logic        is_fd,
	output logic        is_f7,
	output logic        is_xt,
	output logic        is_ide_phys, // ports that reach the drive
	output logic        is_ide10,
	output logic        is_ide11,
	output logic        is_ide_c8    // control block port
);

	logic       iowr;
	logic       iowr_reg; // previous io write level
	logic       iord_reg; // previous io read level
	logic [7:0] loa;

	assign iowr = ~(iorq_n | wr_n);
	assign iord = ~(iorq_n | rd_n);
	assign loa  = a[7:0];

	//////////////////////////////
	// strobes
	//////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= iowr;
			iord_reg <= iord;
			port_wr  <= iowr && !iowr_reg; // rising edge of the write level
			port_rd  <= iord && !iord_reg;
		end
	end

	//////////////////////////////
	// decode
	//////////////////////////////

	assign is_fe     = (loa == zports_pkg::PORT_FE);
	assign is_fd     = (loa == zports_pkg::PORT_FD);
	assign is_f7     = (loa == zports_pkg::PORT_F7);
	assign is_xt     = (loa == zports_pkg::PORT_XT);
	assign is_ide10  = (loa == zports_pkg::IDE_10);
	assign is_ide11  = (loa == zports_pkg::IDE_11);
	assign is_ide_c8 = (loa == zports_pkg::IDE_C8);

	always_comb
	begin
		case (loa)
			zports_pkg::IDE_10, zports_pkg::IDE_30, zports_pkg::IDE_50,
			zports_pkg::IDE_70, zports_pkg::IDE_90, zports_pkg::IDE_B0,
			zports_pkg::IDE_D0, zports_pkg::IDE_F0, zports_pkg::IDE_C8:
				is_ide_phys = 1'b1;
			default:
				is_ide_phys = 1'b0; // #11 stays inside the bridge
		endcase
	end

	// a z80 bus cycle is either a read or a write, never both
	a_strobe_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

// ==== src/mem_paging.sv ====
//////////////////////////////
// #7FFD and #EFF7 paging registers with the 1-meg
// block and 48k lock; also feeds the screen page reload
//////////////////////////////

module mem_paging
(
	input  logic                          zclk,
	input  logic                          rst_n,
	input  logic [zports_pkg::BYTE_W-1:0] din,
	input  logic [15:0]                   a,
	input  logic                          port_wr,
	input  logic                          is_fd,
	input  logic                          is_f7,

	output logic [zports_pkg::BYTE_W-1:0] p7ffd,
	output logic [zports_pkg::BYTE_W-1:0] peff7,
	output logic                          vpage_load,      // screen page follows 7ffd bit 3
	output logic [zports_pkg::BYTE_W-1:0] vpage_from_7ffd,
	output logic [5:0]                    pent1m_page,     // full 1 meg page
	output logic                          pent1m_rom,
	output logic                          pent1m_1m_on,
	output logic                          pent1m_ram0_0
);

	logic [zports_pkg::BYTE_W-1:0] p7ffd_int;
	logic [zports_pkg::BYTE_W-1:0] peff7_int;
	logic                          block1m;       // eff7 bit 2
	logic                          block7ffd_en;  // 48k lock
	logic                          wr_7ffd;
	logic                          wr_eff7;

	assign block1m      = peff7_int[2];
	assign block7ffd_en = p7ffd_int[5] & block1m; // lock only in 128k mode

	assign wr_7ffd = port_wr && is_fd && !a[15] && !block7ffd_en;
	assign wr_eff7 = port_wr && is_f7 && a[8] && !a[12];

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= '0;
			peff7_int <= '0;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_int <= din; // 2:0 page, 3 screen, 4 rom, 5 lock, 7:6 ext page
			if (wr_eff7)
				peff7_int <= din; // 2 block1m, 3 ram at 0000
		end
	end

	// screen page reload rides on the same write
	assign vpage_load      = wr_7ffd;
	assign vpage_from_7ffd = {6'b000001, din[3], 1'b1};

	//////////////////////////////
	// outputs, masked in 128k mode
	//////////////////////////////

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};
	assign peff7 = block1m ?
		{peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]} : peff7_int;

	assign pent1m_rom    = p7ffd_int[4];
	assign pent1m_page   = {p7ffd_int[7:5], p7ffd_int[2:0]};
	assign pent1m_1m_on  = ~peff7_int[2];
	assign pent1m_ram0_0 = peff7_int[3];

	// a locked 7ffd must hold whatever is written to it
	a_lock_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		block7ffd_en |=> $stable(p7ffd_int));

endmodule

// ==== src/video_config.sv ====
//////////////////////////////
// #nnAF extension registers (video config, screen page,
// font map, scroll) and the #FE border colour
//////////////////////////////

module video_config #(
	parameter int SCROLL_W = 9 // scroll offset width, 9..16
)
(
	input  logic                            zclk,
	input  logic                            rst_n,
	input  logic [zports_pkg::BYTE_W-1:0]   din,
	input  logic [7:0]                      a_hi,   // register index
	input  logic                            port_wr,
	input  logic                            is_xt,
	input  logic                            is_fe,
	input  logic                            vpage_load,
	input  logic [zports_pkg::BYTE_W-1:0]   vpage_from_7ffd,

	output logic [zports_pkg::BYTE_W-1:0]   vconfig,
	output logic [zports_pkg::BYTE_W-1:0]   vpage,
	output logic [zports_pkg::FMADDR_W-1:0] fmaddr,
	output logic [SCROLL_W-1:0]             x_offs,
	output logic [SCROLL_W-1:0]             y_offs,
	output logic [3:0]                      border
);

	logic xt_wr;

	assign xt_wr = port_wr && is_xt;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vpage  <= zports_pkg::VPAGE_RESET;
			fmaddr <= '0; // bit 4 off, font map disabled
			x_offs <= '0;
			y_offs <= '0;
		end
		else
		begin
			if (vpage_load)
				vpage <= vpage_from_7ffd; // 7ffd wins over the xt write
			else if (xt_wr && (a_hi == zports_pkg::XT_VPAGE))
				vpage <= din;

			if (xt_wr)
			begin
				case (a_hi)
					zports_pkg::XT_FMADDR: fmaddr                 <= din[zports_pkg::FMADDR_W-1:0];
					zports_pkg::XT_XOFFSL: x_offs[7:0]            <= din;
					zports_pkg::XT_XOFFSH: x_offs[SCROLL_W-1:8]   <= din[SCROLL_W-9:0];
					zports_pkg::XT_YOFFSL: y_offs[7:0]            <= din;
					zports_pkg::XT_YOFFSH: y_offs[SCROLL_W-1:8]   <= din[SCROLL_W-9:0];
					default: ;
				endcase
			end
		end
	end

	// config and border just follow the cpu
	always_ff @(posedge zclk)
	begin
		if (xt_wr && (a_hi == zports_pkg::XT_VCONFIG))
			vconfig <= din;
		if (port_wr && is_fe)
			border <= {din[7], din[2:0]}; // bit 7 is the bright bit
	end

endmodule

// ==== src/ide_bridge.sv ====
//////////////////////////////
// 8 to 16 bit ide bridge, normal (#10/#11) and
// nemo-divide (#10/#10) byte order, driven straight off the z80 bus
//////////////////////////////

module ide_bridge
(
	input  logic                          zclk,
	input  logic                          iorq_n,
	input  logic                          rd_n,
	input  logic                          wr_n,
	input  logic [2:0]                    a_low,    // a[7:5]
	input  logic [zports_pkg::BYTE_W-1:0] din,
	input  logic [15:0]                   idein,
	input  logic                          port_rd,
	input  logic                          port_wr,
	input  logic                          is_ide_phys,
	input  logic                          is_ide10,
	input  logic                          is_ide11,
	input  logic                          is_ide_c8,

	output logic [15:0]                   ideout,
	output logic                          idedataout, // low while reading the drive
	output logic [2:0]                    ide_a,
	output logic                          ide_cs0_n,
	output logic                          ide_cs1_n,
	output logic                          ide_rd_n,
	output logic                          ide_wr_n,
	output logic [zports_pkg::BYTE_W-1:0] ide_rd_data, // even ports
	output logic [zports_pkg::BYTE_W-1:0] ide_hi_data  // port #11
);

	logic        ide_rd_trig    = 1'b0; // high byte pending, divide read
	logic        ide_wrlo_trig  = 1'b0; // low byte stored, divide write
	logic        ide_wrhi_trig  = 1'b0; // high byte stored via #11
	logic        ide_rd_latch   = 1'b0;
	logic        ide_wrlo_latch = 1'b0;
	logic        ide_wrhi_latch = 1'b0;
	logic [15:0] idewrreg;              // pre-written half of the word
	logic [7:0]  idehiin;               // high half of the last word read
	logic        ide_acc;               // any bridge access this cycle

	assign ide_acc = (is_ide_phys || is_ide11) && (port_rd || port_wr);

	//////////////////////////////
	// triggers
	//////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (is_ide10 && port_rd && !ide_rd_trig)
			ide_rd_trig <= 1'b1;
		else if (ide_acc)
			ide_rd_trig <= 1'b0;
	end

	always_ff @(posedge zclk)
	begin
		if (ide_acc)
		begin
			ide_wrhi_trig <= is_ide11 && port_wr;
			ide_wrlo_trig <= is_ide10 && port_wr && !ide_wrhi_trig && !ide_wrlo_trig;
		end
	end

	// data halves
	always_ff @(posedge zclk)
	begin
		if (port_wr && is_ide11)
			idewrreg[15:8] <= din;
		if (port_wr && is_ide10 && !ide_wrlo_trig)
			idewrreg[7:0] <= din;
		if (port_rd && is_ide10 && !ide_rd_trig)
			idehiin <= idein[15:8]; // low half goes to the cpu directly
	end

	// trigger copies frozen for the whole strobe
	always_ff @(posedge zclk)
	begin
		if (rd_n)
			ide_rd_latch <= ide_rd_trig;
		if (wr_n)
		begin
			ide_wrlo_latch <= ide_wrlo_trig;
			ide_wrhi_latch <= ide_wrhi_trig;
		end
	end

	//////////////////////////////
	// drive side
	//////////////////////////////

	assign ide_a     = a_low;
	assign ide_cs0_n = ~(is_ide_phys & ~is_ide_c8);
	assign ide_cs1_n = ~is_ide_c8;

	// second #10 read in divide order comes from idehiin, no drive cycle
	assign ide_rd_n = iorq_n | rd_n | ~is_ide_phys | (ide_rd_latch & is_ide10);
	// first #10 write without a stored half only fills idewrreg
	assign ide_wr_n = iorq_n | wr_n | ~is_ide_phys |
		(is_ide10 & ~ide_wrlo_latch & ~ide_wrhi_latch);

	assign idedataout = ide_rd_n;

	assign ideout[15:8] = ide_wrhi_latch ? idewrreg[15:8] : din;
	assign ideout[7:0]  = ide_wrlo_latch ? idewrreg[7:0]  : din;

	assign ide_rd_data = (ide_rd_latch && is_ide10) ? idehiin : idein[7:0];
	assign ide_hi_data = idehiin;

	// the drive never sees read and write strobes together
	a_ide_strb: assert property (@(posedge zclk) !(!ide_rd_n && !ide_wr_n));

endmodule

// ==== src/port_read_mux.sv ====
//////////////////////////////
// z80 read data for the port block; porthit and the
// bus drive enable
//////////////////////////////

module port_read_mux
(
	input  logic [7:0]                    a_low,
	input  logic                          iord,
	input  logic [zports_pkg::KEYS_W-1:0] keys_in,
	input  logic                          tape_read,
	input  logic [zports_pkg::BYTE_W-1:0] mus_in,
	input  logic [zports_pkg::KJOY_W-1:0] kj_in,
	input  logic [zports_pkg::BYTE_W-1:0] ide_rd_data,
	input  logic [zports_pkg::BYTE_W-1:0] ide_hi_data,

	output logic                          porthit,
	output logic                          dataout, // drive the z80 data bus
	output logic [zports_pkg::BYTE_W-1:0] dout
);

	always_comb
	begin
		porthit = 1'b1;
		case (a_low)
			zports_pkg::PORT_FE, zports_pkg::PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			zports_pkg::KJOY:
				dout = {{(zports_pkg::BYTE_W - zports_pkg::KJOY_W){1'b0}}, kj_in};
			zports_pkg::KMOUSE:
				dout = mus_in;
			zports_pkg::IDE_10, zports_pkg::IDE_30, zports_pkg::IDE_50,
			zports_pkg::IDE_70, zports_pkg::IDE_90, zports_pkg::IDE_B0,
			zports_pkg::IDE_D0, zports_pkg::IDE_F0, zports_pkg::IDE_C8:
				dout = ide_rd_data;
			zports_pkg::IDE_11:
				dout = ide_hi_data;
			zports_pkg::PORT_FD, zports_pkg::PORT_F7, zports_pkg::PORT_XT:
				dout = 8'hFF; // write-only, still ours
			default:
			begin
				dout    = 8'hFF;
				porthit = 1'b0; // leave the bus to others
			end
		endcase
	end

	assign dataout = porthit & iord;

endmodule

// ==== src/zports_top.sv ====
//////////////////////////////
// z80 port block top: bus decode, paging, video regs,
// ide bridge and read mux on one zclk
//////////////////////////////

module zports_top #(
	parameter int SCROLL_W = 9
)
(
	input  logic                            zclk,
	input  logic                            rst_n,
	input  logic [zports_pkg::BYTE_W-1:0]   din,
	input  logic [15:0]                     a,
	input  logic                            iorq_n,
	input  logic                            rd_n,
	input  logic                            wr_n,
	input  logic [15:0]                     idein,
	input  logic [zports_pkg::KEYS_W-1:0]   keys_in,
	input  logic [zports_pkg::BYTE_W-1:0]   mus_in,
	input  logic [zports_pkg::KJOY_W-1:0]   kj_in,
	input  logic                            tape_read,

	output logic [zports_pkg::BYTE_W-1:0]   p7ffd,
	output logic [zports_pkg::BYTE_W-1:0]   peff7,
	output logic [5:0]                      pent1m_page,
	output logic                            pent1m_rom,
	output logic                            pent1m_1m_on,
	output logic                            pent1m_ram0_0,
	output logic [zports_pkg::BYTE_W-1:0]   vconfig,
	output logic [zports_pkg::BYTE_W-1:0]   vpage,
	output logic [zports_pkg::FMADDR_W-1:0] fmaddr,
	output logic [SCROLL_W-1:0]             x_offs,
	output logic [SCROLL_W-1:0]             y_offs,
	output logic [3:0]                      border,
	output logic [15:0]                     ideout,
	output logic                            idedataout,
	output logic [2:0]                      ide_a,
	output logic                            ide_cs0_n,
	output logic                            ide_cs1_n,
	output logic                            ide_rd_n,
	output logic                            ide_wr_n,
	output logic                            porthit,
	output logic                            dataout,
	output logic [zports_pkg::BYTE_W-1:0]   dout
);

	logic                          port_wr;
	logic                          port_rd;
	logic                          iord;
	logic                          is_fe;
	logic                          is_fd;
	logic                          is_f7;
	logic                          is_xt;
	logic                          is_ide_phys;
	logic                          is_ide10;
	logic                          is_ide11;
	logic                          is_ide_c8;
	logic                          vpage_load;
	logic [zports_pkg::BYTE_W-1:0] vpage_from_7ffd;
	logic [zports_pkg::BYTE_W-1:0] ide_rd_data;
	logic [zports_pkg::BYTE_W-1:0] ide_hi_data;

	zbus_decoder u_dec (
		.zclk(zclk), .rst_n(rst_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .a(a),
		.port_wr(port_wr), .port_rd(port_rd), .iord(iord),
		.is_fe(is_fe), .is_fd(is_fd), .is_f7(is_f7), .is_xt(is_xt),
		.is_ide_phys(is_ide_phys), .is_ide10(is_ide10), .is_ide11(is_ide11),
		.is_ide_c8(is_ide_c8)
	);

	mem_paging u_pag (
		.zclk(zclk), .rst_n(rst_n), .din(din), .a(a),
		.port_wr(port_wr), .is_fd(is_fd), .is_f7(is_f7),
		.p7ffd(p7ffd), .peff7(peff7),
		.vpage_load(vpage_load), .vpage_from_7ffd(vpage_from_7ffd),
		.pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0)
	);

	video_config #(.SCROLL_W(SCROLL_W)) u_vid (
		.zclk(zclk), .rst_n(rst_n), .din(din), .a_hi(a[15:8]),
		.port_wr(port_wr), .is_xt(is_xt), .is_fe(is_fe),
		.vpage_load(vpage_load), .vpage_from_7ffd(vpage_from_7ffd),
		.vconfig(vconfig), .vpage(vpage), .fmaddr(fmaddr),
		.x_offs(x_offs), .y_offs(y_offs), .border(border)
	);

	ide_bridge u_ide (
		.zclk(zclk), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a_low(a[7:5]), .din(din), .idein(idein),
		.port_rd(port_rd), .port_wr(port_wr), .is_ide_phys(is_ide_phys),
		.is_ide10(is_ide10), .is_ide11(is_ide11), .is_ide_c8(is_ide_c8),
		.ideout(ideout), .idedataout(idedataout), .ide_a(ide_a),
		.ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n),
		.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n),
		.ide_rd_data(ide_rd_data), .ide_hi_data(ide_hi_data)
	);

	port_read_mux u_rdm (
		.a_low(a[7:0]), .iord(iord), .keys_in(keys_in), .tape_read(tape_read),
		.mus_in(mus_in), .kj_in(kj_in),
		.ide_rd_data(ide_rd_data), .ide_hi_data(ide_hi_data),
		.porthit(porthit), .dataout(dataout), .dout(dout)
	);

endmodule

// ==== tb/zports_tb.sv ====
//////////////////////////////
// testbench for the z80 port block: drives bus cycles
// and checks the DUT against its own model with assertions
//////////////////////////////

module zports_tb;

	localparam int BUS_MAX   = 200;                // bus cycles the run may use
	localparam int CYC_LIMIT = 16 + BUS_MAX * 7;   // reset, then 4 held + 2 idle + slack

	logic        zclk;
	logic        rst_n;
	logic [7:0]  din;
	logic [15:0] a;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic [15:0] idein;
	logic [4:0]  keys_in;
	logic [7:0]  mus_in;
	logic [4:0]  kj_in;
	logic        tape_read;

	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic [7:0]  vconfig;
	logic [7:0]  vpage;
	logic [4:0]  fmaddr;
	logic [8:0]  x_offs;
	logic [8:0]  y_offs;
	logic [3:0]  border;
	logic [15:0] ideout;
	logic        idedataout;
	logic [2:0]  ide_a;
	logic        ide_cs0_n;
	logic        ide_cs1_n;
	logic        ide_rd_n;
	logic        ide_wr_n;
	logic        porthit;
	logic        dataout;
	logic [7:0]  dout;

	// bus phase flags
	logic        busy;          // cycle running, registers not yet settled
	logic        cyc_on;        // strobes low
	logic        cyc_rd;
	logic        ide_chk;
	logic        ideout_chk;
	logic        vconfig_known; // vconfig and border have no reset
	logic        border_known;

	// expected values
	logic [7:0]  exp_dout;
	logic        exp_dataout;
	logic        exp_ide_rd_n;
	logic        exp_ide_wr_n;
	logic        exp_cs0_n;
	logic        exp_cs1_n;
	logic [2:0]  exp_ide_a;     // drive register select, a[7:5]
	logic [15:0] exp_ideout;
	logic [7:0]  m7ffd;         // raw register contents
	logic [7:0]  meff7;
	logic [7:0]  exp_vpage;
	logic [7:0]  exp_vconfig;
	logic [4:0]  exp_fmaddr;
	logic [8:0]  exp_xoffs;
	logic [8:0]  exp_yoffs;
	logic [3:0]  exp_border;
	logic [7:0]  hi_byte;       // high half of the last word read from the drive

	logic [31:0] lfsr = 32'h9b38_2ed1;
	int          errors;
	int          bus_cycles;

	zports_top #(.SCROLL_W(9)) dut (.*);

	initial
	begin
		zclk = 1'b0;
		forever #2 zclk = ~zclk;
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_paging: assert property (@(posedge zclk) disable iff (!rst_n)
		!busy |-> (p7ffd == (meff7[2] ? {3'b000, m7ffd[4:0]} : m7ffd) &&
			peff7 == (meff7[2] ? (meff7 & 8'hB1) : meff7) && vpage == exp_vpage))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: p7ffd %h peff7 %h vpage %h, model %h %h %h",
				$time, $sampled(p7ffd), $sampled(peff7), $sampled(vpage),
				m7ffd, meff7, exp_vpage);
		end

	// 1 meg page is ext bits 7:5 over page bits 2:0, rom on bit 4
	a_pent1m: assert property (@(posedge zclk) disable iff (!rst_n)
		!busy |-> (pent1m_page == {m7ffd[7:5], m7ffd[2:0]} && pent1m_rom == m7ffd[4] &&
			pent1m_1m_on == !meff7[2] && pent1m_ram0_0 == meff7[3]))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: 1m page %h rom %b on %b ram0 %b, model %h %h",
				$time, $sampled(pent1m_page), $sampled(pent1m_rom),
				$sampled(pent1m_1m_on), $sampled(pent1m_ram0_0), m7ffd, meff7);
		end

	a_scroll: assert property (@(posedge zclk) disable iff (!rst_n)
		!busy |-> (x_offs == exp_xoffs && y_offs == exp_yoffs && fmaddr == exp_fmaddr))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: x %h y %h fmaddr %h, expected %h %h %h", $time,
				$sampled(x_offs), $sampled(y_offs), $sampled(fmaddr),
				exp_xoffs, exp_yoffs, exp_fmaddr);
		end

	a_video: assert property (@(posedge zclk) disable iff (!rst_n)
		!busy |-> ((!vconfig_known || vconfig == exp_vconfig) &&
			(!border_known || border == exp_border)))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: vconfig %h border %h, expected %h %h", $time,
				$sampled(vconfig), $sampled(border), exp_vconfig, exp_border);
		end

	a_idle: assert property (@(posedge zclk) disable iff (!rst_n)
		!busy |-> (ide_rd_n && ide_wr_n))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: ide strobe low on an idle bus", $time);
		end

	a_read: assert property (@(posedge zclk) disable iff (!rst_n)
		(cyc_on && cyc_rd) |-> (dout == exp_dout && dataout == exp_dataout &&
			porthit == exp_dataout))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: port %h dout %h dataout %b porthit %b, expected %h %b",
				$time, $sampled(a), $sampled(dout), $sampled(dataout), $sampled(porthit),
				exp_dout, exp_dataout);
		end

	a_ide: assert property (@(posedge zclk) disable iff (!rst_n)
		(cyc_on && ide_chk) |-> (ide_rd_n == exp_ide_rd_n && ide_wr_n == exp_ide_wr_n &&
			ide_cs0_n == exp_cs0_n && ide_cs1_n == exp_cs1_n &&
			ide_a == exp_ide_a && idedataout == exp_ide_rd_n))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: port %h rd_n %b wr_n %b cs0_n %b cs1_n %b a %h dir %b",
				$time, $sampled(a), $sampled(ide_rd_n), $sampled(ide_wr_n),
				$sampled(ide_cs0_n), $sampled(ide_cs1_n), $sampled(ide_a),
				$sampled(idedataout));
			$display("  expected rd_n %b wr_n %b cs0_n %b cs1_n %b a %h dir %b",
				exp_ide_rd_n, exp_ide_wr_n, exp_cs0_n, exp_cs1_n, exp_ide_a, exp_ide_rd_n);
		end

	a_ideout: assert property (@(posedge zclk) disable iff (!rst_n)
		(cyc_on && ideout_chk) |-> (ideout == exp_ideout))
		else
		begin
			errors = errors + 1;
			$display("mismatch at %0t: ideout %h, expected %h", $time,
				$sampled(ideout), exp_ideout);
		end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// task file ports, all of them go out on cs0
	function automatic logic cs0_port(input logic [7:0] p);
		return p inside {8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0};
	endfunction

	// called on a clock edge, returns on a clock edge
	task automatic io_cycle(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		busy   <= 1'b1;
		a      <= addr;
		din    <= data;
		iorq_n <= 1'b0;
		rd_n   <= wr;
		wr_n   <= !wr;
		cyc_on <= 1'b1;
		cyc_rd <= !wr;
		repeat (4) @(posedge zclk); // hold
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		cyc_on <= 1'b0;
		@(posedge zclk);
		busy       <= 1'b0;         // registers settled, model checks resume
		ide_chk    <= 1'b0;
		ideout_chk <= 1'b0;
		@(posedge zclk);
		bus_cycles = bus_cycles + 1;
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] want, input logic hit);
		exp_dout    <= want;
		exp_dataout <= hit;
		io_cycle(1'b0, addr, 8'h00);
	endtask

	task automatic ide_read(input logic [7:0] port, input logic [7:0] want, input logic rdn_want);
		logic [15:0] r;
		r = rand_bits(8);
		exp_ide_rd_n <= rdn_want;
		exp_ide_wr_n <= 1'b1;
		exp_cs0_n    <= !cs0_port(port);
		exp_cs1_n    <= (port != 8'hC8);
		exp_ide_a    <= port[7:5];
		ide_chk      <= 1'b1;
		read_check({r[7:0], port}, want, 1'b1);
	endtask

	task automatic ide_write(input logic [7:0] port, input logic [7:0] data,
		input logic wrn_want, input logic [15:0] word);
		logic [15:0] r;
		r = rand_bits(8);
		exp_ide_rd_n <= 1'b1;
		exp_ide_wr_n <= wrn_want;
		exp_cs0_n    <= !cs0_port(port);
		exp_cs1_n    <= (port != 8'hC8);
		exp_ide_a    <= port[7:5];
		ide_chk      <= 1'b1;
		ideout_chk   <= !wrn_want;   // word only goes out with the strobe
		exp_ideout   <= word;
		io_cycle(1'b1, {r[7:0], port}, data);
	endtask

	// #nnAF register table
	task automatic xt_write(input logic [7:0] idx, input logic [7:0] data);
		case (idx)
			8'd0:
			begin
				exp_vconfig   <= data;
				vconfig_known <= 1'b1;
			end
			8'd1:  exp_vpage      <= data;
			8'd2:  exp_xoffs[7:0] <= data;
			8'd3:  exp_xoffs[8]   <= data[0]; // 9 bit scroll
			8'd4:  exp_yoffs[7:0] <= data;
			8'd5:  exp_yoffs[8]   <= data[0];
			8'd21: exp_fmaddr     <= data[4:0];
			default: ;                        // unused index, no change
		endcase
		io_cycle(1'b1, {idx, 8'hAF}, data);
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial
	begin : stimulus
		logic [7:0]  d;
		logic [7:0]  d2;
		logic [15:0] w;
		logic [15:0] r;
		logic [7:0]  ports [8];
		rst_n = 1'b0;
		din = '0;
		a = '0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		idein = '0;
		keys_in = '0;
		mus_in = '0;
		kj_in = '0;
		tape_read = 1'b0;
		busy = 1'b0;
		cyc_on = 1'b0;
		cyc_rd = 1'b0;
		ide_chk = 1'b0;
		ideout_chk = 1'b0;
		vconfig_known = 1'b0;
		border_known = 1'b0;
		exp_dout = '0;
		exp_dataout = 1'b0;
		exp_ide_rd_n = 1'b1;
		exp_ide_wr_n = 1'b1;
		exp_cs0_n = 1'b1;
		exp_cs1_n = 1'b1;
		exp_ide_a = '0;
		exp_ideout = '0;
		m7ffd = '0;
		meff7 = '0;
		exp_vpage = 8'h05;          // screen page after reset
		exp_vconfig = '0;
		exp_fmaddr = '0;
		exp_xoffs = '0;
		exp_yoffs = '0;
		exp_border = '0;
		hi_byte = '0;
		errors = 0;
		bus_cycles = 0;
		ports = '{8'hC8, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0};

		repeat (16) @(posedge zclk);
		rst_n <= 1'b1;
		repeat (2) @(posedge zclk); // reset values checked here

		// keyboard, joystick, mouse reads
		d = 8'(rand_bits(8));
		w = rand_bits(16);
		keys_in   <= d[4:0];
		tape_read <= d[5];
		mus_in    <= w[7:0];
		kj_in     <= w[12:8];
		read_check(16'h7FFE, {1'b1, d[5], 1'b0, d[4:0]}, 1'b1);
		read_check(16'hBFF6, {1'b1, d[5], 1'b0, d[4:0]}, 1'b1);
		read_check(16'h001F, {3'b000, w[12:8]}, 1'b1);
		read_check(16'hFBDF, w[7:0], 1'b1);
		read_check(16'h7FFD, 8'hFF, 1'b1);  // write-only port still hits
		read_check(16'h003B, 8'hFF, 1'b0);  // nobody home

		// border and #nnAF registers
		d = 8'(rand_bits(8));
		exp_border   <= {d[7], d[2:0]};
		border_known <= 1'b1;
		io_cycle(1'b1, 16'h12FE, d);
		xt_write(zports_pkg::XT_VCONFIG, 8'(rand_bits(8)));
		xt_write(zports_pkg::XT_VPAGE, 8'(rand_bits(8)));
		xt_write(zports_pkg::XT_FMADDR, 8'(rand_bits(8)));
		xt_write(zports_pkg::XT_XOFFSL, 8'(rand_bits(8)));
		xt_write(zports_pkg::XT_XOFFSH, 8'(rand_bits(8)));
		xt_write(zports_pkg::XT_YOFFSL, 8'(rand_bits(8)));
		xt_write(zports_pkg::XT_YOFFSH, 8'(rand_bits(8)));
		repeat (2)
		begin
			r = rand_bits(4);
			xt_write(8'd6 + 8'(r % 15), 8'(rand_bits(8))); // index 6..20
		end

		// paging, then 128k mode and the lock
		d = 8'(rand_bits(8)) & 8'hDF;
		m7ffd     <= d;
		exp_vpage <= {6'b000001, d[3], 1'b1};
		io_cycle(1'b1, 16'h7FFD, d);
		d = 8'(rand_bits(8)) | 8'h04;
		meff7 <= d;
		io_cycle(1'b1, 16'hEFF7, d);
		d = 8'(rand_bits(8)) | 8'h20;
		m7ffd     <= d;
		exp_vpage <= {6'b000001, d[3], 1'b1};
		io_cycle(1'b1, 16'h7FFD, d);
		io_cycle(1'b1, 16'h7FFD, 8'(rand_bits(8))); // locked, ignored

		// normal order ide
		w = rand_bits(16);
		idein   <= w;
		hi_byte = w[15:8];
		ide_read(8'h10, w[7:0], 1'b0);
		idein <= rand_bits(16);
		ide_read(8'h11, hi_byte, 1'b1);
		d  = 8'(rand_bits(8));
		d2 = 8'(rand_bits(8));
		ide_write(8'h11, d, 1'b1, 16'h0000);
		ide_write(8'h10, d2, 1'b0, {d, d2});

		// nemo-divide order
		w = rand_bits(16);
		idein   <= w;
		hi_byte = w[15:8];
		ide_read(8'h10, w[7:0], 1'b0);
		idein <= rand_bits(16);
		ide_read(8'h10, hi_byte, 1'b1);    // second half, no drive cycle
		d  = 8'(rand_bits(8));
		d2 = 8'(rand_bits(8));
		ide_write(8'h10, d, 1'b1, 16'h0000);
		ide_write(8'h10, d2, 1'b0, {d2, d});

		// chip selects over every drive port
		foreach (ports[i])
		begin
			w = rand_bits(16);
			idein <= w;
			ide_read(ports[i], w[7:0], 1'b0);
		end
		ide_read(8'h11, hi_byte, 1'b1);

		repeat (2) @(posedge zclk);
		$display("run complete: %0d bus cycles, %0d errors", bus_cycles, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// run limit
	initial
	begin : watchdog
		int n;
		n = 0;
		while (n < CYC_LIMIT)
		begin
			@(posedge zclk);
			n = n + 1;
		end
		$display("timeout: run did not finish within %0d clock cycles", CYC_LIMIT);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== zports.f ====
src/zports_pkg.sv
src/zbus_decoder.sv
src/mem_paging.sv
src/video_config.sv
src/ide_bridge.sv
src/port_read_mux.sv
src/zports_top.sv
tb/zports_tb.sv

// ==== Bender.yml ====
package:
  name: zports

sources:
  - src/zports_pkg.sv
  - src/zbus_decoder.sv
  - src/mem_paging.sv
  - src/video_config.sv
  - src/ide_bridge.sv
  - src/port_read_mux.sv
  - src/zports_top.sv
  - target: test
    files:
      - tb/zports_tb.sv
